// ==== source/dcache_cfg_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache configuration
// geometry, field widths and address layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dcache_cfg_pkg;

    // geometry
    localparam int WORD_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int NUM_SETS  = 8;
    localparam int NUM_WAYS  = 2;
    localparam int BLK_WORDS = 2;

    // address fields
    localparam int IDX_W     = 3;
    localparam int BLKOFF_W  = 1;
    localparam int BYTEOFF_W = 2;
    localparam int TAG_W     = ADDR_W - IDX_W - BLKOFF_W - BYTEOFF_W;

    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [IDX_W-1:0]    idx_t;
    typedef logic [BLKOFF_W-1:0] blkoff_t;

    typedef struct packed {
        tag_t                 tag;
        idx_t                 idx;
        blkoff_t              blkoff;
        logic [BYTEOFF_W-1:0] byteoff;
    } dcache_addr_t;

    typedef struct packed {
        logic                        valid;
        logic                        dirty;
        tag_t                        tag;
        word_t [BLK_WORDS-1:0]       data;
    } dcache_frame_t;

endpackage

`default_nettype wire

// ==== source/dcache_bus_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache port bundles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package dcache_bus_pkg;

    import dcache_cfg_pkg::*;

    // processor side
    typedef struct packed {
        logic         ren;
        logic         wen;
        logic         halt;
        dcache_addr_t addr;
        word_t        store;
    } dp_req_t;

    typedef struct packed {
        logic  hit;
        word_t load;
        logic  flushed;
    } dp_rsp_t;

    // memory side, held until busy drops
    typedef struct packed {
        logic         ren;
        logic         wen;
        dcache_addr_t addr;
        word_t        store;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t load;
    } mem_rsp_t;

    // controller to storage, lands at the next edge
    typedef struct packed {
        logic          en;
        idx_t          set;
        logic          way;
        dcache_frame_t frame;
        logic          lru_en;
        logic          lru;
    } array_wr_t;

endpackage

`default_nettype wire

// ==== source/dcache_array.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache storage
// frames, lru bits and tag lookup
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dcache_array
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                           CLK,
    input  logic                           nRST,
    input  idx_t                           rd_set,
    input  tag_t                           lookup_tag,
    input  array_wr_t                      wr,
    output dcache_frame_t [NUM_WAYS-1:0]   frames,
    output logic                           lru,
    output logic                           hit,
    output logic                           hit_way
);

    // one entry per set, both ways side by side
    dcache_frame_t [NUM_WAYS-1:0] frame_q [NUM_SETS];

    // bit set means way 1 is the older one
    logic [NUM_SETS-1:0] lru_q;

    logic [NUM_WAYS-1:0] way_match;

    // read side
    assign frames = frame_q[rd_set];
    assign lru    = lru_q[rd_set];

    // tag compare per way
    genvar w;
    generate
        for (w = 0; w < NUM_WAYS; w++) begin : g_match
            assign way_match[w] = frames[w].valid && (frames[w].tag == lookup_tag);
        end
    endgenerate

    assign hit = |way_match;

    // matching way, way 0 wins a tie
    always_comb begin
        hit_way = 1'b0;
        for (int i = NUM_WAYS - 1; i >= 0; i--) begin
            if (way_match[i]) begin
                hit_way = i[0];
            end
        end
    end

    // frame writes
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                frame_q[s] <= '0;
            end
        end else if (wr.en) begin
            frame_q[wr.set][wr.way] <= wr.frame;
        end
    end

    // replacement bits
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lru_q <= '0;
        end else if (wr.lru_en) begin
            lru_q[wr.set] <= wr.lru;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache_ctrl.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache controller
// hits, miss refill, write-back and flush
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dcache_ctrl
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic                           CLK,
    input  logic                           nRST,
    input  dp_req_t                        dp_req,
    output dp_rsp_t                        dp_rsp,
    output mem_req_t                       mem_req,
    input  mem_rsp_t                       mem_rsp,
    output idx_t                           rd_set,
    output tag_t                           lookup_tag,
    input  dcache_frame_t [NUM_WAYS-1:0]   frames,
    input  logic                           lru,
    input  logic                           hit,
    input  logic                           hit_way,
    output array_wr_t                      wr
);

    typedef enum logic [3:0] {
        IDLE, WB_WORD0, WB_WORD1, LOAD_WORD0, LOAD_WORD1,
        FLUSH_CHECK, FLUSH_WORD0, FLUSH_WORD1, HALTED
    } state_t;

    state_t state, next_state;

    // way index sits above the set index
    logic [IDX_W:0] flush_cnt, next_flush_cnt;
    logic           flush_last;
    logic           flushing;
    logic           req_active;

    dcache_addr_t  req_addr;
    dcache_frame_t hit_frame;
    dcache_frame_t victim_frame;
    dcache_frame_t flush_frame;

    // block aligned address of one word
    function automatic dcache_addr_t word_addr(tag_t tag, idx_t idx, blkoff_t off);
        dcache_addr_t a;
        a.tag     = tag;
        a.idx     = idx;
        a.blkoff  = off;
        a.byteoff = '0;
        return a;
    endfunction

    assign req_addr   = dp_req.addr;
    assign req_active = dp_req.ren || dp_req.wen;
    assign flushing   = (state == FLUSH_CHECK) || (state == FLUSH_WORD0) ||
                        (state == FLUSH_WORD1);
    assign flush_last = (flush_cnt == (IDX_W+1)'(NUM_SETS * NUM_WAYS - 1));

    // lookup follows the flush walk while flushing
    assign rd_set     = flushing ? flush_cnt[IDX_W-1:0] : req_addr.idx;
    assign lookup_tag = req_addr.tag;

    assign hit_frame    = frames[hit_way];
    assign victim_frame = frames[lru];
    assign flush_frame  = frames[flush_cnt[IDX_W]];

    // datapath response
    assign dp_rsp.hit     = (state == IDLE) && !dp_req.halt && req_active && hit;
    assign dp_rsp.load    = hit_frame.data[req_addr.blkoff];
    assign dp_rsp.flushed = (state == HALTED);

    always_comb begin
        next_state     = state;
        next_flush_cnt = flush_cnt;
        mem_req        = '0;
        wr             = '0;
        wr.set         = req_addr.idx;
        wr.way         = lru;
        case (state)
            IDLE: begin
                if (dp_req.halt) begin
                    next_state = FLUSH_CHECK;
                end else if (req_active && hit) begin
                    wr.way    = hit_way;
                    wr.lru_en = 1'b1;
                    wr.lru    = ~hit_way;
                    if (dp_req.wen) begin
                        wr.en                            = 1'b1;
                        wr.frame                         = hit_frame;
                        wr.frame.dirty                   = 1'b1;
                        wr.frame.data[req_addr.blkoff]   = dp_req.store;
                    end
                end else if (req_active) begin
                    // victim is the lru way
                    if (victim_frame.valid && victim_frame.dirty)
                        next_state = WB_WORD0;
                    else
                        next_state = LOAD_WORD0;
                end
            end
            WB_WORD0, WB_WORD1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = word_addr(victim_frame.tag, req_addr.idx,
                                          blkoff_t'(state == WB_WORD1));
                mem_req.store = victim_frame.data[state == WB_WORD1];
                if (!mem_rsp.busy)
                    next_state = (state == WB_WORD0) ? WB_WORD1 : LOAD_WORD0;
            end
            LOAD_WORD0, LOAD_WORD1: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = word_addr(req_addr.tag, req_addr.idx,
                                         blkoff_t'(state == LOAD_WORD1));
                if (!mem_rsp.busy) begin
                    wr.en                             = 1'b1;
                    wr.frame                          = victim_frame;
                    wr.frame.tag                      = req_addr.tag;
                    wr.frame.dirty                    = 1'b0;
                    // frame goes valid with the second word
                    wr.frame.valid                    = (state == LOAD_WORD1);
                    wr.frame.data[state == LOAD_WORD1] = mem_rsp.load;
                    next_state = (state == LOAD_WORD0) ? LOAD_WORD1 : IDLE;
                end
            end
            FLUSH_CHECK: begin
                if (flush_frame.valid && flush_frame.dirty) begin
                    next_state = FLUSH_WORD0;
                end else if (flush_last) begin
                    next_state = HALTED;
                end else begin
                    next_flush_cnt = flush_cnt + (IDX_W+1)'(1);
                end
            end
            FLUSH_WORD0, FLUSH_WORD1: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = word_addr(flush_frame.tag, flush_cnt[IDX_W-1:0],
                                          blkoff_t'(state == FLUSH_WORD1));
                mem_req.store = flush_frame.data[state == FLUSH_WORD1];
                if (!mem_rsp.busy) begin
                    if (state == FLUSH_WORD0) begin
                        next_state = FLUSH_WORD1;
                    end else begin
                        // drop the frame once it is written back
                        wr.en          = 1'b1;
                        wr.set         = flush_cnt[IDX_W-1:0];
                        wr.way         = flush_cnt[IDX_W];
                        wr.frame       = flush_frame;
                        wr.frame.valid = 1'b0;
                        wr.frame.dirty = 1'b0;
                        if (flush_last) begin
                            next_state = HALTED;
                        end else begin
                            next_state     = FLUSH_CHECK;
                            next_flush_cnt = flush_cnt + (IDX_W+1)'(1);
                        end
                    end
                end
            end
            HALTED: begin
                next_state = HALTED;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= IDLE;
            flush_cnt <= '0;
        end else begin
            state     <= next_state;
            flush_cnt <= next_flush_cnt;
        end
    end

endmodule

`default_nettype wire

// ==== source/dcache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// two-way write-back data cache top
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dcache
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  dp_req_t  dp_req,
    output dp_rsp_t  dp_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // lookup path
    idx_t                         rd_set;
    tag_t                         lookup_tag;
    dcache_frame_t [NUM_WAYS-1:0] frames;
    logic                         lru;
    logic                         hit;
    logic                         hit_way;

    // update path
    array_wr_t                    wr;

    dcache_array u_array (
        .CLK        (CLK),
        .nRST       (nRST),
        .rd_set     (rd_set),
        .lookup_tag (lookup_tag),
        .wr         (wr),
        .frames     (frames),
        .lru        (lru),
        .hit        (hit),
        .hit_way    (hit_way)
    );

    dcache_ctrl u_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .dp_rsp     (dp_rsp),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .rd_set     (rd_set),
        .lookup_tag (lookup_tag),
        .frames     (frames),
        .lru        (lru),
        .hit        (hit),
        .hit_way    (hit_way),
        .wr         (wr)
    );

endmodule

`default_nettype wire

// ==== verif/dcache_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache checker
// compares loads and memory words, counts errors
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module dcache_checker
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
(
    input  logic     CLK,
    input  logic     nRST,
    input  dp_req_t  dp_req,
    input  dp_rsp_t  dp_rsp,
    input  mem_req_t mem_req,
    input  logic     chk_load,
    input  logic     chk_mem,
    input  int       chk_id,
    input  word_t    chk_addr,
    input  word_t    chk_exp,
    input  word_t    mem_word,
    output int       load_errs,
    output int       mem_errs,
    output int       proto_errs
);

    logic flushed_seen;

    // everything settles half a cycle after the driving edge
    always @(negedge CLK) begin
        if (!nRST) begin
            load_errs    = 0;
            mem_errs     = 0;
            proto_errs   = 0;
            flushed_seen = 1'b0;
        end else begin
            if (chk_load && dp_rsp.hit && dp_req.ren && (dp_rsp.load !== chk_exp)) begin
                $display("[FAIL] pattern %0d load 0x%08h: expected 0x%08h, actual 0x%08h",
                         chk_id, chk_addr, chk_exp, dp_rsp.load);
                load_errs++;
            end
            if (chk_mem && (mem_word !== chk_exp)) begin
                $display("[FAIL] pattern %0d memory 0x%08h: expected 0x%08h, actual 0x%08h",
                         chk_id, chk_addr, chk_exp, mem_word);
                mem_errs++;
            end
            // memory port handshake rules
            if (mem_req.ren && mem_req.wen) begin
                $display("error: memory read and write requested together at %0t", $time);
                proto_errs++;
            end
            if (dp_rsp.hit && !dp_req.ren && !dp_req.wen) begin
                $display("error: hit raised with no request pending at %0t", $time);
                proto_errs++;
            end
            // flushed is sticky until reset
            if (flushed_seen && !dp_rsp.flushed) begin
                $display("error: flushed dropped again at %0t", $time);
                proto_errs++;
            end
            if (dp_rsp.flushed && !dp_req.halt) begin
                $display("error: flushed raised without a halt at %0t", $time);
                proto_errs++;
            end
            flushed_seen = flushed_seen || dp_rsp.flushed;
        end
    end

endmodule

`default_nettype wire

// ==== verif/tb_dcache.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data cache testbench
// pattern-driven requests and a memory model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/10ps
`default_nettype none

module tb_dcache
    import dcache_cfg_pkg::*;
    import dcache_bus_pkg::*;
();

    localparam int MAX_PAT    = 64;
    localparam int CLK_PERIOD = 20;

    logic     CLK;
    logic     nRST;
    dp_req_t  dp_req;
    dp_rsp_t  dp_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;

    // four words per pattern: op, addr, store, expected
    logic [31:0] pat [4*MAX_PAT];
    int          n_pat;
    int          tb_errs;

    word_t       mem [256];
    logic [1:0]  busy_cnt;
    integer      seed = 89363;

    logic        chk_load;
    logic        chk_mem;
    int          chk_id;
    word_t       chk_addr;
    word_t       chk_exp;
    word_t       mem_word;
    int          load_errs;
    int          mem_errs;
    int          proto_errs;

    dcache DUT (
        .CLK     (CLK),
        .nRST    (nRST),
        .dp_req  (dp_req),
        .dp_rsp  (dp_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    dcache_checker chk (
        .CLK        (CLK),
        .nRST       (nRST),
        .dp_req     (dp_req),
        .dp_rsp     (dp_rsp),
        .mem_req    (mem_req),
        .chk_load   (chk_load),
        .chk_mem    (chk_mem),
        .chk_id     (chk_id),
        .chk_addr   (chk_addr),
        .chk_exp    (chk_exp),
        .mem_word   (mem_word),
        .load_errs  (load_errs),
        .mem_errs   (mem_errs),
        .proto_errs (proto_errs)
    );

    initial begin
        CLK = 1'b0;
        forever #(CLK_PERIOD/2) CLK = ~CLK;
    end

    function automatic logic [7:0] word_index(input dcache_addr_t a);
        logic [31:0] flat;
        flat = a;
        return flat[9:2];
    endfunction

    // memory model, 0 to 3 busy cycles per word
    assign mem_rsp.busy = (mem_req.ren || mem_req.wen) && (busy_cnt != 2'd0);
    assign mem_rsp.load = mem[word_index(mem_req.addr)];
    assign mem_word     = mem[chk_addr[9:2]];

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            busy_cnt <= '0;
            for (int i = 0; i < 256; i++) begin
                mem[i] <= word_t'(i * 4);
            end
        end else if (mem_req.ren || mem_req.wen) begin
            if (mem_rsp.busy) begin
                busy_cnt <= busy_cnt - 2'd1;
            end else begin
                // word moves this edge, draw the wait for the next one
                busy_cnt <= 2'($random(seed));
                if (mem_req.wen) begin
                    mem[word_index(mem_req.addr)] <= mem_req.store;
                end
            end
        end
    end

    task automatic wait_for_hit();
        do @(negedge CLK); while (!dp_rsp.hit);
    endtask

    task automatic wait_for_flush();
        do @(negedge CLK); while (!dp_rsp.flushed);
    endtask

    task automatic run_pattern(input int n);
        logic [31:0] op;
        op = pat[4*n];
        @(posedge CLK);
        #2;
        dp_req.ren   = 1'b0;
        dp_req.wen   = 1'b0;
        dp_req.addr  = dcache_addr_t'(pat[4*n+1]);
        dp_req.store = pat[4*n+2];
        chk_load     = 1'b0;
        chk_mem      = 1'b0;
        chk_id       = n;
        chk_addr     = pat[4*n+1];
        chk_exp      = pat[4*n+3];
        case (op)
            32'd1: begin
                dp_req.ren = 1'b1;
                chk_load   = 1'b1;
                wait_for_hit();
            end
            32'd2: begin
                dp_req.wen = 1'b1;
                wait_for_hit();
            end
            32'd3: begin
                dp_req.halt = 1'b1;
                wait_for_flush();
            end
            32'd4: begin
                chk_mem = 1'b1;
                @(negedge CLK);
            end
            default: begin
                $display("error: pattern %0d has unknown opcode %0h", n, op);
                tb_errs++;
            end
        endcase
    endtask

    // watchdog, sized by the pattern count
    initial begin
        @(posedge nRST);
        repeat (n_pat * 40) @(posedge CLK);
        $display("error: run timed out after %0d cycles", n_pat * 40);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        nRST     = 1'b0;
        dp_req   = '0;
        chk_load = 1'b0;
        chk_mem  = 1'b0;
        chk_id   = 0;
        chk_addr = '0;
        chk_exp  = '0;
        tb_errs  = 0;
        for (int i = 0; i < 4*MAX_PAT; i++) begin
            pat[i] = '0;
        end
        $readmemh("verif/dcache_patterns.mem", pat);
        n_pat = 0;
        while (n_pat < MAX_PAT && pat[4*n_pat] != 32'd0) begin
            n_pat++;
        end
        repeat (5) @(posedge CLK);
        #2;
        nRST = 1'b1;
        for (int i = 0; i < n_pat; i++) begin
            run_pattern(i);
        end
        @(posedge CLK);
        #2;
        chk_load = 1'b0;
        chk_mem  = 1'b0;
        @(posedge CLK);
        $display("load mismatches %0d, memory mismatches %0d, protocol errors %0d, other %0d",
                 load_errs, mem_errs, proto_errs, tb_errs);
        if (load_errs + mem_errs + proto_errs + tb_errs == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
source/dcache_cfg_pkg.sv
source/dcache_bus_pkg.sv
source/dcache_array.sv
source/dcache_ctrl.sv
source/dcache.sv
verif/dcache_checker.sv
verif/tb_dcache.sv

// ==== Makefile ====
# Verilator flow for the data cache testbench
VERILATOR ?= verilator
TOP       ?= tb_dcache
RTL_TOP   ?= dcache
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(filter source/%,$(SRCS))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides the result, a crash counts as failure too
run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verif/dcache_patterns.mem ====
// columns: op addr store expected, all hex
// op 1 read, 2 write, 3 halt, 4 memory check, 0 ends the list
// read miss into set 1, then the other word of the block
1 00000008 00000000 00000008
1 0000000C 00000000 0000000C
// store then load, memory still holds the old word
2 00000008 A5A50001 00000000
1 00000008 00000000 A5A50001
4 00000008 00000000 00000008
2 0000000C 0000BEEF 00000000
2 0000000C CAFE000C 00000000
1 0000000C 00000000 CAFE000C
// three tags in set 2
1 00000010 00000000 00000010
1 00000050 00000000 00000050
1 00000010 00000000 00000010
1 00000090 00000000 00000090
1 00000014 00000000 00000014
1 00000054 00000000 00000054
1 00000094 00000000 00000094
// dirty victim in set 3 goes back to memory
2 00000018 11110018 00000000
2 0000001C 2222001C 00000000
1 00000058 00000000 00000058
1 00000098 00000000 00000098
4 00000018 00000000 11110018
4 0000001C 00000000 2222001C
2 0000009C 3333009C 00000000
2 00000024 44440024 00000000
// halt and flush, then the memory image
3 00000000 00000000 00000000
4 00000008 00000000 A5A50001
4 0000000C 00000000 CAFE000C
4 00000018 00000000 11110018
4 0000009C 00000000 3333009C
4 00000024 00000000 44440024
4 00000098 00000000 00000098
4 00000020 00000000 00000020
4 00000010 00000000 00000010
4 00000058 00000000 00000058
4 000003FC 00000000 000003FC
0 00000000 00000000 00000000
